// File: src/armIsaPkg.sv
`default_nettype none

package armIsaPkg;

  typedef logic [31:0] instrT;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'ha, condLt = 4'hb,
    condGt = 4'hc, condLe = 4'hd, condAl = 4'he, condNv = 4'hf
  } condT;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3,
    opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7,
    opTst = 4'h8, opTeq = 4'h9, opCmp = 4'ha, opCmn = 4'hb,
    opOrr = 4'hc, opMov = 4'hd, opBic = 4'he, opMvn = 4'hf
  } dpOpT;

  typedef enum logic [3:0] {
    clsDpImm, clsDpReg,
    clsLoad, clsStore,          // LDR/STR word and byte
    clsLoadHalf, clsStoreHalf,  // LDRH/STRH
    clsBranch, clsBx,
    clsUndef
  } instrClassT;

  // ==================================================
  // Field positions
  localparam int condMsb     = 31;
  localparam int condLsb     = 28;
  localparam int classMsb    = 27;
  localparam int classLsb    = 25;
  localparam int iBit        = 25;  // Immediate operand / register offset
  localparam int opMsb       = 24;
  localparam int opLsb       = 21;
  localparam int uBit        = 23;  // Offset added when set
  localparam int bBit        = 22;  // Byte access, or immediate form for halfwords
  localparam int sBit        = 20;
  localparam int lBit        = 20;  // Load when set
  localparam int rdMsb       = 15;
  localparam int rdLsb       = 12;
  localparam int extBit      = 7;   // Multiply / extra load-store space
  localparam int shMsb       = 6;
  localparam int shLsb       = 5;
  localparam int regShiftBit = 4;
  localparam int bxMsb       = 27;
  localparam int bxLsb       = 4;

  localparam logic [1:0]  shHalf    = 2'b01;          // Unsigned halfword
  localparam logic [23:0] bxPattern = 24'h12_fff1;   // BX Rm, bits 27:4

endpackage

`default_nettype wire

// File: src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  typedef logic [3:0] flagsT;     // N Z C V
  typedef logic [3:0] byteMaskT;  // One enable per byte lane
  typedef logic [1:0] srcSelT;
  typedef logic [6:0] vectorT;

  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluAnd   = 3'd1,
    aluOr    = 3'd2,
    aluXor   = 3'd3,
    aluPassB = 3'd4
  } aluOpT;

  // Flag bit positions within flagsT
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // ==================================================
  // Register-source select
  localparam srcSelT regSrcNone  = 2'b00;
  localparam srcSelT regSrcPc    = 2'b01;  // Rn read as PC
  localparam srcSelT regSrcStore = 2'b10;  // Second port reads Rd

  // Immediate extension select
  localparam srcSelT immSrcDp     = 2'b00;  // Rotated 8-bit
  localparam srcSelT immSrcMem    = 2'b01;  // 12-bit offset
  localparam srcSelT immSrcBranch = 2'b10;  // 24-bit word offset
  localparam srcSelT immSrcHalf   = 2'b11;  // Split 4+4 bit offset

  // Exception vectors
  localparam vectorT undefVector = 7'h04;
  localparam vectorT resetVector = 7'h00;

endpackage

`default_nettype wire

// File: src/mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
  input  armIsaPkg::instrT instrD,
  output ctrlPkg::srcSelT  regSrcD,
  output ctrlPkg::srcSelT  immSrcD,
  output logic             aluSrcD,
  output logic             memtoRegD,
  output logic             regWriteD,
  output logic             memWriteD,
  output logic             branchD,
  output logic             bxD,
  output logic             byteAccessD,
  output logic             halfwordD,
  output logic             undefD,
  output armIsaPkg::dpOpT  aluControlD,
  output logic             flagWriteD
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  instrClassT instrClass;
  logic       isHalfword;
  logic       isMisc;
  dpOpT       memOp;

  // Extra load/store space, unsigned halfword only
  assign isHalfword = instrD[extBit] & instrD[regShiftBit] &
                      (instrD[shMsb:shLsb] == shHalf);
  // Compare group without S is MRS/MSR space
  assign isMisc = (instrD[opMsb:opMsb-1] == 2'b10) & ~instrD[sBit];
  assign memOp  = instrD[uBit] ? opAdd : opSub;  // Up/down offset

  // ==================================================
  // Classification
  always_comb begin
    instrClass = clsUndef;
    case (instrD[classMsb:classLsb])
      3'b000: begin
        if (instrD[bxMsb:bxLsb] == bxPattern) instrClass = clsBx;
        else if (isHalfword) instrClass = instrD[lBit] ? clsLoadHalf : clsStoreHalf;
        else if (!instrD[regShiftBit] && !isMisc) instrClass = clsDpReg;
      end
      3'b001: if (!isMisc) instrClass = clsDpImm;
      3'b010: instrClass = instrD[lBit] ? clsLoad : clsStore;
      3'b011: begin
        if (!instrD[regShiftBit]) instrClass = instrD[lBit] ? clsLoad : clsStore;
      end
      3'b101: instrClass = clsBranch;
      default: instrClass = clsUndef;  // LDM/STM, coprocessor, SWI
    endcase
  end

  // ==================================================
  // Control word per class
  always_comb begin
    regSrcD     = regSrcNone;
    immSrcD     = immSrcDp;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    bxD         = 1'b0;
    byteAccessD = 1'b0;
    halfwordD   = 1'b0;
    undefD      = 1'b0;
    aluControlD = opAdd;
    flagWriteD  = 1'b0;
    case (instrClass)
      clsDpImm, clsDpReg: begin
        aluSrcD     = (instrClass == clsDpImm);
        regWriteD   = 1'b1;  // Compares drop this in execute
        aluControlD = dpOpT'(instrD[opMsb:opLsb]);
        flagWriteD  = instrD[sBit];
      end
      clsLoad, clsStore: begin
        regSrcD     = (instrClass == clsStore) ? regSrcStore : regSrcNone;
        immSrcD     = immSrcMem;
        aluSrcD     = ~instrD[iBit];  // I clear means immediate offset here
        memtoRegD   = (instrClass == clsLoad);
        regWriteD   = (instrClass == clsLoad);
        memWriteD   = (instrClass == clsStore);
        byteAccessD = instrD[bBit];
        aluControlD = memOp;
      end
      clsLoadHalf, clsStoreHalf: begin
        regSrcD     = (instrClass == clsStoreHalf) ? regSrcStore : regSrcNone;
        immSrcD     = immSrcHalf;
        aluSrcD     = instrD[bBit];  // Immediate offset form
        memtoRegD   = (instrClass == clsLoadHalf);
        regWriteD   = (instrClass == clsLoadHalf);
        memWriteD   = (instrClass == clsStoreHalf);
        halfwordD   = 1'b1;
        aluControlD = memOp;
      end
      clsBranch: begin
        regSrcD = regSrcPc;   // PC + offset
        immSrcD = immSrcBranch;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      clsBx: begin
        branchD     = 1'b1;
        bxD         = 1'b1;
        aluControlD = opMov;  // Target straight from Rm
      end
      default: undefD = 1'b1;  // All writes stay off
    endcase
  end

endmodule

`default_nettype wire

// File: src/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
  input  armIsaPkg::dpOpT aluControlE,
  input  logic            aluOpE,
  input  logic            carryFlagE,
  output ctrlPkg::aluOpT  aluOperationE,
  output logic            invertBE,
  output logic            reverseInputsE,
  output logic            aluCarryE,
  output logic            doNotWriteRegE
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  always_comb begin
    aluOperationE  = aluAdd;  // Plain add outside data processing
    invertBE       = 1'b0;
    reverseInputsE = 1'b0;
    aluCarryE      = 1'b0;
    doNotWriteRegE = 1'b0;
    if (aluOpE) begin
      case (aluControlE)
        opAnd: aluOperationE = aluAnd;
        opEor: aluOperationE = aluXor;
        opSub, opCmp: begin   // A + ~B + 1
          invertBE  = 1'b1;
          aluCarryE = 1'b1;
        end
        opRsb: begin          // B + ~A + 1
          invertBE       = 1'b1;
          reverseInputsE = 1'b1;
          aluCarryE      = 1'b1;
        end
        opAdc: aluCarryE = carryFlagE;
        opSbc: begin
          invertBE  = 1'b1;
          aluCarryE = carryFlagE;
        end
        opRsc: begin
          invertBE       = 1'b1;
          reverseInputsE = 1'b1;
          aluCarryE      = carryFlagE;
        end
        opTst: aluOperationE = aluAnd;
        opTeq: aluOperationE = aluXor;
        opOrr: aluOperationE = aluOr;
        opMov: aluOperationE = aluPassB;
        opBic: begin
          aluOperationE = aluAnd;
          invertBE      = 1'b1;
        end
        opMvn: begin
          aluOperationE = aluPassB;
          invertBE      = 1'b1;
        end
        default: aluOperationE = aluAdd;  // ADD, CMN
      endcase
      // Test and compare only touch flags
      doNotWriteRegE = (aluControlE inside {opTst, opTeq, opCmp, opCmn});
    end
  end

endmodule

`default_nettype wire

// File: src/condUnit.sv
`timescale 1ns/1ps
`default_nettype none

module condUnit (
  input  armIsaPkg::condT condE,
  input  ctrlPkg::flagsT  flagsE,
  input  ctrlPkg::flagsT  aluFlagsE,
  input  logic            flagWriteE,
  output logic            condExE,
  output ctrlPkg::flagsT  flagsNextE
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flagsE[flagN];
  assign z = flagsE[flagZ];
  assign c = flagsE[flagC];
  assign v = flagsE[flagV];

  // ==================================================
  // Condition check on forwarded flags
  always_comb begin
    case (condE)
      condEq: condExE = z;
      condNe: condExE = ~z;
      condCs: condExE = c;
      condCc: condExE = ~c;
      condMi: condExE = n;
      condPl: condExE = ~n;
      condVs: condExE = v;
      condVc: condExE = ~v;
      condHi: condExE = c & ~z;     // Unsigned higher
      condLs: condExE = ~c | z;
      condGe: condExE = (n == v);   // Signed compares
      condLt: condExE = (n != v);
      condGt: condExE = ~z & (n == v);
      condLe: condExE = z | (n != v);
      condAl: condExE = 1'b1;
      default: condExE = 1'b0;      // NV never executes
    endcase
  end

  // New flags only from an executed S instruction
  assign flagsNextE = (flagWriteE & condExE) ? aluFlagsE : flagsE;

endmodule

`default_nettype wire

// File: src/memMask.sv
`timescale 1ns/1ps
`default_nettype none

module memMask (
  input  logic              byteAccessE,
  input  logic              halfwordE,
  input  logic [1:0]        offsetE,
  output ctrlPkg::byteMaskT byteMaskE
);

  always_comb begin
    if (byteAccessE) begin
      byteMaskE = 4'b0001 << offsetE;  // Single lane
    end else if (halfwordE) begin
      byteMaskE = offsetE[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
    end else begin
      byteMaskE = 4'b1111;  // Full word
    end
  end

endmodule

`default_nettype wire

// File: src/statusReg.sv
`timescale 1ns/1ps
`default_nettype none

module statusReg (
  input  logic            clk,
  input  logic            rstN,
  input  logic            stallW,
  input  logic            setFlagsW,
  input  logic            undefW,
  input  ctrlPkg::flagsT  flagsNextW,
  output ctrlPkg::flagsT  statusFlags,
  output ctrlPkg::vectorT vectorAddressW
);
  import ctrlPkg::*;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      statusFlags    <= '0;
      vectorAddressW <= resetVector;
    end else begin
      // Commit NZCV as the setter retires
      if (!stallW && setFlagsW) statusFlags <= flagsNextW;

      // Undefined trap wins, held even under stall
      if (undefW) vectorAddressW <= undefVector;
      else if (!stallW) vectorAddressW <= resetVector;
    end
  end

endmodule

`default_nettype wire

// File: src/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
  input  logic              clk,
  input  logic              rstN,
  input  armIsaPkg::instrT  instrD,
  input  ctrlPkg::flagsT    aluFlagsE,
  input  logic [1:0]        aluResultLowE,
  input  logic              stallE,
  input  logic              flushE,
  input  logic              stallM,
  input  logic              stallW,
  input  logic              flushW,
  // Decode
  output ctrlPkg::srcSelT   regSrcD,
  output ctrlPkg::srcSelT   immSrcD,
  output logic              undefinedInstr,
  output logic              pcWritePendingF,
  // Execute
  output logic              aluSrcE,
  output ctrlPkg::aluOpT    aluOperationE,
  output logic              invertBE,
  output logic              reverseInputsE,
  output logic              aluCarryE,
  output logic              branchTakenE,
  // Memory
  output logic              memWriteM,
  output logic              regWriteM,
  output ctrlPkg::byteMaskT byteMaskM,
  // Writeback
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output logic              loadByteW,
  output logic [1:0]        byteOffsetW,
  output logic              halfwordW,
  output ctrlPkg::flagsT    statusFlagsW,
  output ctrlPkg::vectorT   vectorAddressW
);
  import armIsaPkg::*;
  import ctrlPkg::*;

  logic aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, bxD;
  logic byteAccessD, halfwordD, undefD, flagWriteD, pcSrcD, aluOpD;
  dpOpT aluControlD;

  logic [10:0] ctrlD, ctrlE;
  logic aluOpE, memtoRegE, regWriteE, memWriteE, branchE, pcSrcE;
  logic flagWriteE, byteAccessE, halfwordE, undefE;
  dpOpT aluControlE;
  condT condE;
  logic condExE, doNotWriteRegE, setFlagsE;
  flagsT flagsE, flagsNextE;
  byteMaskT byteMaskE;

  logic [13:0] ctrlM;
  logic memtoRegM, pcSrcM, setFlagsM, undefM, byteAccessM, halfwordM;
  logic [1:0] byteOffsetM;
  flagsT flagsNextM;

  logic [8:0] ctrlW;
  logic setFlagsW, undefW;
  flagsT flagsNextW;

  // ==================================================
  // Decode
  mainDecoder mainDec (
    .instrD(instrD), .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcD(aluSrcD),
    .memtoRegD(memtoRegD), .regWriteD(regWriteD), .memWriteD(memWriteD),
    .branchD(branchD), .bxD(bxD), .byteAccessD(byteAccessD), .halfwordD(halfwordD),
    .undefD(undefD), .aluControlD(aluControlD), .flagWriteD(flagWriteD)
  );

  assign pcSrcD = ((instrD[rdMsb:rdLsb] == 4'hf) & regWriteD) | branchD | bxD;  // PC redirect
  assign aluOpD = ~undefD;  // Opcode decode for every defined instruction
  assign undefinedInstr  = undefD;
  assign pcWritePendingF = pcSrcD | pcSrcE | pcSrcM;

  // ==================================================
  // Execute register, flush beats stall
  assign ctrlD = {aluSrcD, aluOpD, memtoRegD, regWriteD, memWriteD, branchD,
                  pcSrcD, flagWriteD, byteAccessD, halfwordD, undefD};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) ctrlE <= '0;
    else if (flushE) ctrlE <= '0;  // Bubble
    else if (!stallE) ctrlE <= ctrlD;
  end

  always_ff @(posedge clk) begin
    if (!stallE) begin
      aluControlE <= aluControlD;
      condE       <= condT'(instrD[condMsb:condLsb]);
    end
  end

  assign {aluSrcE, aluOpE, memtoRegE, regWriteE, memWriteE, branchE,
          pcSrcE, flagWriteE, byteAccessE, halfwordE, undefE} = ctrlE;

  // Flag forwarding, youngest setter first
  always_comb begin
    if (setFlagsM) flagsE = flagsNextM;
    else if (setFlagsW) flagsE = flagsNextW;
    else flagsE = statusFlagsW;
  end

  aluDecoder aluDec (
    .aluControlE(aluControlE), .aluOpE(aluOpE), .carryFlagE(flagsE[flagC]),
    .aluOperationE(aluOperationE), .invertBE(invertBE), .reverseInputsE(reverseInputsE),
    .aluCarryE(aluCarryE), .doNotWriteRegE(doNotWriteRegE)
  );

  condUnit condChk (
    .condE(condE), .flagsE(flagsE), .aluFlagsE(aluFlagsE), .flagWriteE(flagWriteE),
    .condExE(condExE), .flagsNextE(flagsNextE)
  );

  memMask maskGen (
    .byteAccessE(byteAccessE), .halfwordE(halfwordE), .offsetE(aluResultLowE),
    .byteMaskE(byteMaskE)
  );

  assign branchTakenE = branchE & condExE;
  assign setFlagsE    = flagWriteE & condExE;

  // ==================================================
  // Memory register, no flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) ctrlM <= '0;
    else if (!stallM) begin
      ctrlM <= {memWriteE & condExE,                        // Squashed on cond fail
                regWriteE & condExE & ~doNotWriteRegE,      // Compares never write
                memtoRegE, pcSrcE & condExE, setFlagsE, undefE,
                byteAccessE, halfwordE, byteMaskE, aluResultLowE};
    end
  end

  assign {memWriteM, regWriteM, memtoRegM, pcSrcM, setFlagsM, undefM,
          byteAccessM, halfwordM, byteMaskM, byteOffsetM} = ctrlM;

  // Next NZCV travelling with M and W for forwarding
  always_ff @(posedge clk) begin
    if (!stallM) flagsNextM <= flagsNextE;
    if (!stallW) flagsNextW <= flagsNextM;
  end

  // ==================================================
  // Writeback register and status
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) ctrlW <= '0;
    else if (flushW) ctrlW <= '0;
    else if (!stallW) begin
      ctrlW <= {memtoRegM, regWriteM, pcSrcM, setFlagsM, undefM,
                byteAccessM, halfwordM, byteOffsetM};
    end
  end

  assign {memtoRegW, regWriteW, pcSrcW, setFlagsW, undefW,
          loadByteW, halfwordW, byteOffsetW} = ctrlW;

  statusReg cpsr (
    .clk(clk), .rstN(rstN), .stallW(stallW), .setFlagsW(setFlagsW), .undefW(undefW),
    .flagsNextW(flagsNextW), .statusFlags(statusFlagsW), .vectorAddressW(vectorAddressW)
  );

endmodule

`default_nettype wire

// File: bench/clkGen.sv
`timescale 1ns/1ps
`default_nettype none

module clkGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Reset held for two rising edges
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/controller_props.sv
`timescale 1ns/1ps
`default_nettype none

module controller_props (
  input logic              clk,
  input logic              rstN,
  input logic              memWriteM,
  input logic              regWriteM,
  input ctrlPkg::byteMaskT byteMaskM,
  input logic              undefW,
  input ctrlPkg::vectorT   vectorAddressW
);
  import ctrlPkg::*;

  // Pipeline comes out of reset empty
  quietAfterReset: assert property (@(posedge clk)
    $rose(rstN) |=> (!memWriteM && !regWriteM))
    else $error("memory or register write right after reset");

  storeHasLanes: assert property (@(posedge clk) disable iff (!rstN)
    memWriteM |-> (byteMaskM != '0))
    else $error("store with empty byte mask");

  // Trap vector follows an undefined retire
  undefVectorSet: assert property (@(posedge clk) disable iff (!rstN)
    undefW |=> (vectorAddressW == undefVector))
    else $error("undefined instruction gave wrong vector");

endmodule

bind controller controller_props propsInst (
  .clk(clk), .rstN(rstN), .memWriteM(memWriteM), .regWriteM(regWriteM),
  .byteMaskM(byteMaskM), .undefW(undefW), .vectorAddressW(vectorAddressW)
);

`default_nettype wire

// File: bench/controllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module controllerTb;
  import armIsaPkg::*;
  import ctrlPkg::*;

  // Control bits in a row: regW memToReg pcSrc br memW byteAcc half sets undef
  localparam int cRegW = 8, cToReg = 7, cPc = 6, cBr = 5, cMemW = 4;
  localparam int cByte = 3, cHalf = 2, cSets = 1, cUndef = 0;
  localparam int numRows = 25;
  localparam int cycleLimit = numRows + 20;
  localparam instrT nop = 32'hE1A0_0000;  // MOV r0, r0

  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  aluFlags;
    logic [1:0]  off;
    logic [1:0]  hz;    // stallE, flushE
    logic [8:0]  ctl;
    logic [3:0]  mask;  // Expected byteMaskM
    logic [10:0] dec;   // regSrc immSrc in D, aluSrc aluOp invB reverse carry in E
  } rowT;

  rowT rows [numRows];
  logic clk, rstN, stallE, flushE, stallM, stallW, flushW;
  instrT instrD;
  flagsT aluFlagsE, specFlags, commitFlags;
  logic [1:0] aluResultLowE;
  srcSelT regSrcD, immSrcD;
  logic undefinedInstr, pcWritePendingF, aluSrcE, invertBE, reverseInputsE, aluCarryE;
  logic branchTakenE, memWriteM, regWriteM, memtoRegW, regWriteW, pcSrcW, loadByteW;
  logic halfwordW, lastUndefW;
  aluOpT aluOperationE;
  byteMaskT byteMaskM;
  logic [1:0] byteOffsetW;
  flagsT statusFlagsW;
  vectorT vectorAddressW;
  int eHist [64];  // Row in E per cycle, -1 for bubble
  logic pHist [64];
  int cyc, cycleCount, prev;

  clkGen clkGenInst (.clk(clk), .rstN(rstN));

  controller controller_inst (.*);

  // ==================================================
  // Reference helpers
  function automatic logic condPass(logic [3:0] cond, flagsT f);
    logic n, z, c, v;
    n = f[flagN];
    z = f[flagZ];
    c = f[flagC];
    v = f[flagV];
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'ha: return n == v;
      4'hb: return n != v;
      4'hc: return !z && (n == v);
      4'hd: return z || (n != v);
      4'he: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkVal(string name, int got, int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1, "check failed");
    end
  endtask

  // ==================================================
  // One clock cycle: drive D and E side, then check every stage
  task automatic runCycle(int d, logic flushNow, int e, logic stallNow);
    int m;
    int w;
    logic pass;
    logic expPend;
    logic [6:0] expE;
    @(posedge clk);
    #1;
    instrD        = (d >= 0) ? rows[d].instr : nop;
    flushE        = flushNow;
    stallE        = stallNow;
    aluFlagsE     = (e >= 0) ? rows[e].aluFlags : 4'h0;
    aluResultLowE = (e >= 0) ? rows[e].off : 2'd0;
    #1;
    pass = 1'b0;
    if (e >= 0) begin  // Condition seen in E with all older setters applied
      pass = condPass(rows[e].instr[31:28], specFlags);
      if (pass && rows[e].ctl[cSets]) specFlags = rows[e].aluFlags;
      checkVal("branchTakenE", branchTakenE, rows[e].ctl[cBr] & pass);
    end else checkVal("branchTakenE", branchTakenE, 0);
    // Bubble in E decodes as a plain add
    expE = (e >= 0) ? rows[e].dec[6:0] : 7'h00;
    checkVal("aluSrcE", aluSrcE, expE[6]);
    checkVal("aluOperationE", aluOperationE, expE[5:3]);
    checkVal("invertBE", invertBE, expE[2]);
    checkVal("reverseInputsE", reverseInputsE, expE[1]);
    checkVal("aluCarryE", aluCarryE, expE[0]);
    eHist[cyc + 3] = e;
    pHist[cyc + 3] = pass;
    if (d >= 0) begin
      checkVal("undefinedInstr", undefinedInstr, rows[d].ctl[cUndef]);
      checkVal("regSrcD", regSrcD, rows[d].dec[10:9]);
      checkVal("immSrcD", immSrcD, rows[d].dec[8:7]);
    end
    m = eHist[cyc + 2];
    w = eHist[cyc + 1];
    expPend = ((d >= 0) && rows[d].ctl[cPc]) || ((e >= 0) && rows[e].ctl[cPc]) ||
              ((m >= 0) && rows[m].ctl[cPc] && pHist[cyc + 2]);
    checkVal("pcWritePendingF", pcWritePendingF, expPend);
    // Memory stage
    checkVal("memWriteM", memWriteM, (m >= 0) && rows[m].ctl[cMemW] && pHist[cyc + 2]);
    checkVal("regWriteM", regWriteM, (m >= 0) && rows[m].ctl[cRegW] && pHist[cyc + 2]);
    if (m >= 0) checkVal("byteMaskM", byteMaskM, rows[m].mask);
    // Status lags W by one edge
    checkVal("statusFlagsW", statusFlagsW, commitFlags);
    checkVal("vectorAddressW", vectorAddressW, lastUndefW ? undefVector : resetVector);
    if (w >= 0) begin
      checkVal("regWriteW", regWriteW, rows[w].ctl[cRegW] & pHist[cyc + 1]);
      checkVal("pcSrcW", pcSrcW, rows[w].ctl[cPc] & pHist[cyc + 1]);
      checkVal("memtoRegW", memtoRegW, rows[w].ctl[cToReg]);
      checkVal("loadByteW", loadByteW, rows[w].ctl[cByte]);
      checkVal("halfwordW", halfwordW, rows[w].ctl[cHalf]);
      checkVal("byteOffsetW", byteOffsetW, rows[w].off);
      if (pHist[cyc + 1] && rows[w].ctl[cSets]) commitFlags = rows[w].aluFlags;
      lastUndefW = rows[w].ctl[cUndef];
    end else begin  // Bubble retires with nothing set
      checkVal("regWriteW", regWriteW, 0);
      checkVal("pcSrcW", pcSrcW, 0);
      checkVal("memtoRegW", memtoRegW, 0);
      checkVal("loadByteW", loadByteW, 0);
      checkVal("halfwordW", halfwordW, 0);
      lastUndefW = 1'b0;
    end
    cyc++;
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles without finishing", cycleCount);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  // ==================================================
  // Stimulus table and main sequence
  initial begin
    instrD = nop;
    aluFlagsE = 4'h0;
    aluResultLowE = 2'd0;
    {stallE, stallM, stallW, flushW} = '0;
    flushE = 1'b1;  // E stays empty until the first row
    specFlags = 4'h0;
    commitFlags = 4'h0;
    lastUndefW = 1'b0;
    cyc = 0;
    cycleCount = 0;
    prev = -1;
    foreach (eHist[i]) begin
      eHist[i] = -1;
      pHist[i] = 1'b0;
    end
    void'($urandom(32'h99f5_1c75));
    rows[0]  = '{32'hE291_0001, 4'h4, 2'd0, 2'b00, 9'b100000010, 4'hf, 11'h040};  // ADDS, Z
    rows[1]  = '{32'h03A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOVEQ via M
    rows[2]  = '{32'h13A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOVNE via W
    rows[3]  = '{32'hE351_0000, 4'h8, 2'd0, 2'b00, 9'b000000010, 4'hf, 11'h045};  // CMP, N
    rows[4]  = '{32'hE291_0001, 4'h1, 2'd0, 2'b00, 9'b100000010, 4'hf, 11'h040};  // ADDS, V
    rows[5]  = '{32'hA3A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOVGE
    rows[6]  = '{32'hB3A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOVLT
    rows[7]  = '{32'hE041_0002, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h005};  // SUB reg
    rows[8]  = '{32'hE3A0_0005, 4'h0, 2'd0, 2'b10, 9'b100000000, 4'hf, 11'h060};  // MOV, stalled
    rows[9]  = '{32'hE291_0001, 4'hf, 2'd0, 2'b01, 9'b100000010, 4'hf, 11'h040};  // ADDS, flushed
    rows[10] = '{32'h03A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOVEQ
    rows[11] = '{32'hE591_0004, 4'h0, 2'd1, 2'b00, 9'b110000000, 4'hf, 11'h0c0};  // LDR
    rows[12] = '{32'hE5C1_0000, 4'h0, 2'd0, 2'b00, 9'b000011000, 4'h1, 11'h4c0};  // STRB
    rows[13] = '{32'hE5C1_0000, 4'h0, 2'd1, 2'b00, 9'b000011000, 4'h2, 11'h4c0};
    rows[14] = '{32'hE5C1_0000, 4'h0, 2'd2, 2'b00, 9'b000011000, 4'h4, 11'h4c0};
    rows[15] = '{32'hE5C1_0000, 4'h0, 2'd3, 2'b00, 9'b000011000, 4'h8, 11'h4c0};
    rows[16] = '{32'hE1D1_00B2, 4'h0, 2'd2, 2'b00, 9'b110000100, 4'hc, 11'h1c0};  // LDRH
    rows[17] = '{32'hE1C1_00B0, 4'h0, 2'd0, 2'b00, 9'b000010100, 4'h3, 11'h5c0};  // STRH
    rows[18] = '{32'hE1C1_00B0, 4'h0, 2'd3, 2'b00, 9'b000010100, 4'hc, 11'h5c0};
    rows[19] = '{32'hEA00_0010, 4'h0, 2'd0, 2'b00, 9'b001100000, 4'hf, 11'h340};  // B
    rows[20] = '{32'h0A00_0010, 4'h0, 2'd0, 2'b00, 9'b001100000, 4'hf, 11'h340};  // BEQ, Z clear
    rows[21] = '{32'hE12F_FF1E, 4'h0, 2'd0, 2'b00, 9'b001100000, 4'hf, 11'h020};  // BX lr
    rows[22] = '{32'hE1A0_F00E, 4'h0, 2'd0, 2'b00, 9'b101000000, 4'hf, 11'h020};  // MOV pc, lr
    rows[23] = '{32'hE610_0010, 4'h0, 2'd0, 2'b00, 9'b000000001, 4'hf, 11'h000};  // Undefined
    rows[24] = '{32'hE3A0_0005, 4'h0, 2'd0, 2'b00, 9'b100000000, 4'hf, 11'h060};  // MOV
    // Filler destination registers, never r15
    foreach (rows[i]) begin
      if (rows[i].instr[15:12] == 4'h0) rows[i].instr[15:12] = 4'($urandom % 15);
    end
    @(posedge rstN);
    for (int i = 0; i < numRows; i++) begin
      if (prev >= 0 && rows[prev].hz[1]) begin
        runCycle(i, 1'b0, prev, 1'b1);  // E held, D held
        runCycle(i, rows[i].hz[0], prev, 1'b0);
      end else begin
        runCycle(i, rows[i].hz[0], prev, 1'b0);
      end
      prev = rows[i].hz[0] ? -1 : i;
    end
    runCycle(-1, 1'b1, prev, 1'b0);
    repeat (4) runCycle(-1, 1'b1, -1, 1'b0);  // Drain with bubbles
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
src/armIsaPkg.sv
src/ctrlPkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/condUnit.sv
src/memMask.sv
src/statusReg.sv
src/controller.sv
bench/clkGen.sv
bench/controller_props.sv
bench/controllerTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = controllerTb
FILELIST = filelist.f
OBJDIR   = obj_dir

BIN  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJDIR)
